//--- plicTop.f
logic/plicPkg.sv
logic/plicGateway.sv
logic/plicRegBus.sv
logic/plicTarget.sv
logic/plicTop.sv
testbench/plicTop_checker.sv
testbench/plicTop_tb.sv

//--- Makefile
# Verilator build and run of the PLIC testbench

TOP := plicTop_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f plicTop.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@grep -q "STATUS: PASS" sim.log && echo "run passed" || \
		(echo "run failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- testbench/plicTop_tb.sv
`default_nettype none

module plicTop_tb;

  localparam logic [37:0] BaseAddr    = 38'h0011000000;
  localparam logic [37:0] PendingAddr = BaseAddr + 38'h1000;
  localparam int RespTimeout = 10;
  localparam int WaitTimeout = 12;

  logic        clk = 1'b0;
  logic        rstN;
  logic        regReq;
  logic        regWe;
  logic [37:0] regAddr;
  logic [31:0] regWdata;
  logic        regRvalid;
  logic [31:0] regRdata;
  logic        regErr;
  logic        irqUart;
  logic        irqSd;
  logic        irqEth;
  logic        irqDmaTx;
  logic        irqDmaRx;
  logic        irqPhy;
  logic        irqPs2;
  logic [1:0]  irq;

  integer seed;
  int errors = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int errAtStart = 0;
  logic [2:0] hi;
  logic [2:0] lo;
  logic [31:0] rnd;

  plicTop plicTop_i (
    .clk_i       (clk),
    .rstN_i      (rstN),
    .regReq_i    (regReq),
    .regWe_i     (regWe),
    .regAddr_i   (regAddr),
    .regWdata_i  (regWdata),
    .regRvalid_o (regRvalid),
    .regRdata_o  (regRdata),
    .regErr_o    (regErr),
    .irqUart_i   (irqUart),
    .irqSd_i     (irqSd),
    .irqEth_i    (irqEth),
    .irqDmaTx_i  (irqDmaTx),
    .irqDmaRx_i  (irqDmaRx),
    .irqPhy_i    (irqPhy),
    .irqPs2_i    (irqPs2),
    .irq_o       (irq)
  );

  always #50 clk = ~clk;

  //////////////////////////////
  // address map

  function automatic logic [37:0] prioAddr(input int id);
    return BaseAddr + 38'(id * 4);
  endfunction

  function automatic logic [37:0] enableAddr(input int ctx);
    return BaseAddr + 38'h2000 + 38'(ctx * 'h80);
  endfunction

  function automatic logic [37:0] thrAddr(input int ctx);
    return BaseAddr + 38'h200000 + 38'(ctx * 'h1000);
  endfunction

  function automatic logic [37:0] claimAddr(input int ctx);
    return thrAddr(ctx) + 38'h4;
  endfunction

  //////////////////////////////
  // checks and register access

  task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic access(input logic we, input logic [37:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err);
    int waitCount;
    @(negedge clk);
    regReq = 1'b1;
    regWe = we;
    regAddr = addr;
    regWdata = wdata;
    @(negedge clk);
    regReq = 1'b0;
    regWe = 1'b0;
    waitCount = 0;
    while (!regRvalid && waitCount < RespTimeout) begin
      @(negedge clk);
      waitCount++;
    end
    if (!regRvalid) begin
      errors++;
      $display("timeout at time %0t: no response for address 0x%0h", $time, addr);
    end
    rdata = regRdata;
    err = regErr;
  endtask

  task automatic writeReg(input logic [37:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic err;
    access(1'b1, addr, data, rd, err);
    checkEq(32'(err), 32'h0, $sformatf("error flag on write to 0x%0h", addr));
  endtask

  task automatic expectReg(input logic [37:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rd;
    logic err;
    access(1'b0, addr, 32'h0, rd, err);
    checkEq(32'(err), 32'h0, {what, " (error flag)"});
    checkEq(rd, exp, what);
  endtask

  // poll the pending register until it shows the mask
  task automatic waitPending(input logic [31:0] mask, input string what);
    logic [31:0] rd;
    logic err;
    int tries;
    tries = 0;
    rd = 32'h0;
    while (rd != mask && tries < WaitTimeout) begin
      access(1'b0, PendingAddr, 32'h0, rd, err);
      tries++;
    end
    checkEq(rd, mask, what);
  endtask

  task automatic waitIrq(input int ctx, input logic level, input string what);
    int waitCount;
    waitCount = 0;
    while (irq[ctx] !== level && waitCount < WaitTimeout) begin
      @(negedge clk);
      waitCount++;
    end
    if (irq[ctx] !== level) begin
      errors++;
      $display("timeout at time %0t: irq_o[%0d] never went to %0b (%s)", $time, ctx, level,
               what);
    end
  endtask

  task automatic startTest();
    errAtStart = errors;
    testsRun++;
  endtask

  task automatic finishTest(input string name);
    if (errors == errAtStart) begin
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: failed with %0d errors", name, errors - errAtStart);
    end
  endtask

  //////////////////////////////
  // stimulus

  initial begin
    seed = 32'h8226_a256;
    rstN = 1'b0;
    regReq = 1'b0;
    regWe = 1'b0;
    regAddr = '0;
    regWdata = '0;
    irqUart = 1'b0;
    irqSd = 1'b0;
    irqEth = 1'b0;
    irqDmaTx = 1'b0;
    irqDmaRx = 1'b0;
    irqPhy = 1'b0;
    irqPs2 = 1'b0;
    repeat (8) @(negedge clk);
    rstN = 1'b1;

    startTest();
    checkEq(32'(irq), 32'h0, "irq_o after reset");
    for (int id = 1; id < 8; id++) begin
      expectReg(prioAddr(id), 32'h0, $sformatf("priority %0d after reset", id));
    end
    for (int c = 0; c < 2; c++) begin
      expectReg(enableAddr(c), 32'h0, $sformatf("enable ctx%0d after reset", c));
      expectReg(thrAddr(c), 32'h0, $sformatf("threshold ctx%0d after reset", c));
    end
    expectReg(PendingAddr, 32'h0, "pending after reset");
    finishTest("resetState");

    startTest();
    for (int id = 1; id < 8; id++) begin
      rnd = $random(seed);
      writeReg(prioAddr(id), rnd);
      expectReg(prioAddr(id), rnd & 32'h7, $sformatf("priority %0d readback", id));
    end
    // bit 0 is the reserved source
    writeReg(enableAddr(0), 32'hFFFF_FFFF);
    expectReg(enableAddr(0), 32'hFE, "enable ctx0 readback");
    writeReg(enableAddr(1), 32'h0000_0155);
    expectReg(enableAddr(1), 32'h54, "enable ctx1 readback");
    writeReg(thrAddr(1), 32'hFFFF_FFFF);
    expectReg(thrAddr(1), 32'h7, "threshold ctx1 readback");
    writeReg(BaseAddr + 38'h3000, 32'h1234_5678);
    expectReg(BaseAddr + 38'h3000, 32'h0, "unmapped offset readback");
    for (int id = 1; id < 8; id++) begin
      writeReg(prioAddr(id), 32'h0);
    end
    writeReg(enableAddr(0), 32'h0);
    writeReg(enableAddr(1), 32'h0);
    writeReg(thrAddr(1), 32'h0);
    finishTest("readBack");

    startTest();
    begin
      logic [31:0] rd;
      logic err;
      access(1'b1, 38'h0012000004, 32'h5, rd, err);
      checkEq(32'(err), 32'h1, "error flag on out-of-window write");
      checkEq(rd, 32'h0, "data on out-of-window write");
      access(1'b1, 38'h0111200000, 32'h7, rd, err);
      checkEq(32'(err), 32'h1, "error flag on write with high address bits");
      access(1'b0, 38'h0012000004, 32'h0, rd, err);
      checkEq(32'(err), 32'h1, "error flag on out-of-window read");
      checkEq(rd, 32'h0, "data on out-of-window read");
    end
    expectReg(prioAddr(1), 32'h0, "priority 1 after out-of-window write");
    expectReg(thrAddr(0), 32'h0, "threshold ctx0 after out-of-window write");
    finishTest("outOfWindow");

    startTest();
    writeReg(prioAddr(1), 32'h3);
    writeReg(enableAddr(0), 32'h2);
    irqUart = 1'b1;
    waitIrq(0, 1'b1, "uart enabled in ctx0");
    checkEq(32'(irq[1]), 32'h0, "irq_o[1] with uart not enabled");
    writeReg(thrAddr(0), 32'h3);
    waitIrq(0, 1'b0, "threshold equal to priority");
    irqUart = 1'b0;
    writeReg(thrAddr(0), 32'h0);
    expectReg(claimAddr(0), 32'h1, "claim of uart");
    writeReg(claimAddr(0), 32'h1);
    expectReg(PendingAddr, 32'h0, "pending after uart complete");
    writeReg(enableAddr(0), 32'h0);
    writeReg(prioAddr(1), 32'h0);
    waitIrq(0, 1'b0, "uart cleaned up");
    finishTest("irqRouting");

    startTest();
    hi = {1'b1, 2'($random(seed))};
    lo = hi - 3'd1;
    writeReg(prioAddr(2), 32'(lo));
    writeReg(prioAddr(3), 32'(hi));
    writeReg(prioAddr(5), 32'(hi));
    writeReg(enableAddr(0), 32'h2C);
    irqSd = 1'b1;
    irqEth = 1'b1;
    irqDmaRx = 1'b1;
    waitPending(32'h2C, "sd, eth and dmaRx pending");
    expectReg(claimAddr(1), 32'h0, "claim in ctx1 with nothing enabled");
    expectReg(PendingAddr, 32'h2C, "pending after empty claim");
    waitIrq(0, 1'b1, "three sources in ctx0");
    // eth and dmaRx tie on priority
    expectReg(claimAddr(0), 32'h3, "first claim");
    expectReg(PendingAddr, 32'h24, "pending after first claim");
    expectReg(claimAddr(0), 32'h5, "second claim");
    expectReg(PendingAddr, 32'h04, "pending after second claim");
    expectReg(claimAddr(0), 32'h2, "third claim");
    expectReg(PendingAddr, 32'h0, "pending after third claim");
    expectReg(PendingAddr, 32'h0, "in-service sources held high");
    expectReg(claimAddr(0), 32'h0, "claim with nothing eligible");
    waitIrq(0, 1'b0, "all sources in service");
    finishTest("claimOrder");

    startTest();
    writeReg(claimAddr(1), 32'h3);
    expectReg(PendingAddr, 32'h0, "eth after complete in ctx1");
    writeReg(claimAddr(0), 32'h3);
    waitPending(32'h08, "eth after complete in ctx0");
    waitIrq(0, 1'b1, "eth pending again");
    expectReg(claimAddr(0), 32'h3, "claim of eth again");
    finishTest("completeRules");

    repeat (2) @(negedge clk);
    $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             testsRun, testsFailed, errors, plicTop_i.chk.failCount);
    if (errors == 0 && plicTop_i.chk.failCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/plicTop_checker.sv
`default_nettype none

module plicTop_checker import plicPkg::*; (
  input wire logic                   clk_i,
  input wire logic                   rstN_i,
  input wire logic                   regReq_i,
  input wire logic                   regRvalid_o,
  input wire logic                   regErr_o,
  input wire logic [NumContexts-1:0] irq_o
);

  // count of failed assertions
  int failCount = 0;

  //////////////////////////////
  // register port response

  respAfterReq: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    regReq_i |=> regRvalid_o
  ) else begin
    failCount++;
    $error("response missing one cycle after a request");
  end

  noRespWithoutReq: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    !regReq_i |=> !regRvalid_o
  ) else begin
    failCount++;
    $error("response without a request in the cycle before");
  end

  errOnlyWithResp: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    regErr_o |-> regRvalid_o
  ) else begin
    failCount++;
    $error("error flag raised outside a response");
  end

  //////////////////////////////
  // interrupt outputs

  // reset must clear every context line
  irqLowAfterReset: assert property (
    @(posedge clk_i)
    !rstN_i |=> irq_o == '0
  ) else begin
    failCount++;
    $error("interrupt output high in the cycle after reset");
  end

endmodule

bind plicTop plicTop_checker chk (
  .clk_i       (clk_i),
  .rstN_i      (rstN_i),
  .regReq_i    (regReq_i),
  .regRvalid_o (regRvalid_o),
  .regErr_o    (regErr_o),
  .irq_o       (irq_o)
);

`default_nettype wire

//--- logic/plicTop.sv
`default_nettype none

module plicTop import plicPkg::*; (
  input  logic                   clk_i,
  input  logic                   rstN_i,

  // register port
  input  logic                   regReq_i,
  input  logic                   regWe_i,
  input  logic [AddrWidth-1:0]   regAddr_i,
  input  logic [DataWidth-1:0]   regWdata_i,
  output logic                   regRvalid_o,
  output logic [DataWidth-1:0]   regRdata_o,
  output logic                   regErr_o,

  // level device lines
  input  logic                   irqUart_i,
  input  logic                   irqSd_i,
  input  logic                   irqEth_i,
  input  logic                   irqDmaTx_i,
  input  logic                   irqDmaRx_i,
  input  logic                   irqPhy_i,
  input  logic                   irqPs2_i,

  output logic [NumContexts-1:0] irq_o
);

  logic [NumSources-1:1] srcLines;
  logic [NumSources-1:0] pending;
  logic [NumSources-1:0][PrioWidth-1:0] prio;
  logic [NumSources-1:0] prioWe;
  logic [PrioWidth-1:0] prioWdata;
  logic [NumSources-1:0] claim;
  logic [NumSources-1:0] complete;

  logic enWe;
  logic thrWe;
  logic claimReq;
  logic completeReq;
  logic [CtxIdxWidth-1:0] ctxSel;
  logic [DataWidth-1:0] wdata;
  logic [SrcIdWidth-1:0] claimId;
  logic [NumContexts-1:0][NumSources-1:0] enable;
  logic [NumContexts-1:0][PrioWidth-1:0] threshold;

  //////////////////////////////
  // irq routing

  always_comb begin
    srcLines[1] = irqUart_i;
    srcLines[2] = irqSd_i;
    srcLines[3] = irqEth_i;
    srcLines[4] = irqDmaTx_i;
    srcLines[5] = irqDmaRx_i;
    srcLines[6] = irqPhy_i;
    srcLines[7] = irqPs2_i;
  end

  // slot 0 never pends
  assign pending[0] = 1'b0;
  assign prio[0] = '0;

  //////////////////////////////
  // instances

  plicRegBus regBus (
    .clk_i         (clk_i),
    .rstN_i        (rstN_i),
    .regReq_i      (regReq_i),
    .regWe_i       (regWe_i),
    .regAddr_i     (regAddr_i),
    .regWdata_i    (regWdata_i),
    .regRvalid_o   (regRvalid_o),
    .regRdata_o    (regRdata_o),
    .regErr_o      (regErr_o),
    .prioWe_o      (prioWe),
    .prioWdata_o   (prioWdata),
    .pending_i     (pending),
    .prio_i        (prio),
    .enWe_o        (enWe),
    .thrWe_o       (thrWe),
    .claimReq_o    (claimReq),
    .completeReq_o (completeReq),
    .ctxSel_o      (ctxSel),
    .wdata_o       (wdata),
    .claimId_i     (claimId),
    .enable_i      (enable),
    .threshold_i   (threshold)
  );

  for (genvar i = 1; i < NumSources; i++) begin : gwGen
    plicGateway gateway (
      .clk_i       (clk_i),
      .rstN_i      (rstN_i),
      .src_i       (srcLines[i]),
      .prioWe_i    (prioWe[i]),
      .prioWdata_i (prioWdata),
      .claim_i     (claim[i]),
      .complete_i  (complete[i]),
      .pending_o   (pending[i]),
      .prio_o      (prio[i])
    );
  end

  plicTarget target (
    .clk_i         (clk_i),
    .rstN_i        (rstN_i),
    .enWe_i        (enWe),
    .thrWe_i       (thrWe),
    .claimReq_i    (claimReq),
    .completeReq_i (completeReq),
    .ctxSel_i      (ctxSel),
    .wdata_i       (wdata),
    .pending_i     (pending),
    .prio_i        (prio),
    .claimId_o     (claimId),
    .enable_o      (enable),
    .threshold_o   (threshold),
    .claim_o       (claim),
    .complete_o    (complete),
    .irq_o         (irq_o)
  );

endmodule

`default_nettype wire

//--- logic/plicTarget.sv
`default_nettype none

module plicTarget import plicPkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rstN_i,

  // from the register decoder
  input  logic                                   enWe_i,
  input  logic                                   thrWe_i,
  input  logic                                   claimReq_i,
  input  logic                                   completeReq_i,
  input  logic [CtxIdxWidth-1:0]                 ctxSel_i,
  input  logic [DataWidth-1:0]                   wdata_i,

  // gateway state
  input  logic [NumSources-1:0]                  pending_i,
  input  logic [NumSources-1:0][PrioWidth-1:0]   prio_i,

  output logic [SrcIdWidth-1:0]                  claimId_o,
  output logic [NumContexts-1:0][NumSources-1:0] enable_o,
  output logic [NumContexts-1:0][PrioWidth-1:0]  threshold_o,
  output logic [NumSources-1:0]                  claim_o,
  output logic [NumSources-1:0]                  complete_o,
  output logic [NumContexts-1:0]                 irq_o
);

  logic [NumContexts-1:0][SrcIdWidth-1:0] bestId;
  logic [SrcIdWidth-1:0] completeId;
  logic completeIdOk;

  //////////////////////////////
  // enables and thresholds

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      enable_o <= '0;
      threshold_o <= '0;
    end else begin
      if (enWe_i) begin
        // source 0 is reserved
        enable_o[ctxSel_i] <= {wdata_i[NumSources-1:1], 1'b0};
      end
      if (thrWe_i) begin
        threshold_o[ctxSel_i] <= wdata_i[PrioWidth-1:0];
      end
    end
  end

  //////////////////////////////
  // best source per context

  // strict compare keeps the lowest ID on a tie
  always_comb begin : bestSel
    logic [PrioWidth-1:0] bestPrio;
    for (int c = 0; c < NumContexts; c++) begin
      bestId[c] = '0;
      bestPrio = threshold_o[c];
      for (int s = 1; s < NumSources; s++) begin
        if (pending_i[s] && enable_o[c][s] && prio_i[s] > bestPrio) begin
          bestId[c] = SrcIdWidth'(s);
          bestPrio = prio_i[s];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      irq_o <= '0;
    end else begin
      for (int c = 0; c < NumContexts; c++) begin
        irq_o[c] <= bestId[c] != '0;
      end
    end
  end

  //////////////////////////////
  // claim and complete

  assign claimId_o = bestId[ctxSel_i];

  always_comb begin
    claim_o = '0;
    if (claimReq_i && claimId_o != '0) begin
      claim_o[claimId_o] = 1'b1;
    end
  end

  assign completeId = wdata_i[SrcIdWidth-1:0];
  // ignore IDs beyond the source range
  assign completeIdOk = wdata_i[DataWidth-1:SrcIdWidth] == '0;

  always_comb begin
    complete_o = '0;
    if (completeReq_i && completeIdOk && enable_o[ctxSel_i][completeId]) begin
      complete_o[completeId] = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/plicRegBus.sv
`default_nettype none

module plicRegBus import plicPkg::*; (
  input  logic                                       clk_i,
  input  logic                                       rstN_i,

  // register port
  input  logic                                       regReq_i,
  input  logic                                       regWe_i,
  input  logic [AddrWidth-1:0]                       regAddr_i,
  input  logic [DataWidth-1:0]                       regWdata_i,
  output logic                                       regRvalid_o,
  output logic [DataWidth-1:0]                       regRdata_o,
  output logic                                       regErr_o,

  // to and from the gateways
  output logic [NumSources-1:0]                      prioWe_o,
  output logic [PrioWidth-1:0]                       prioWdata_o,
  input  logic [NumSources-1:0]                      pending_i,
  input  logic [NumSources-1:0][PrioWidth-1:0]       prio_i,

  // to and from the context arbiter
  output logic                                       enWe_o,
  output logic                                       thrWe_o,
  output logic                                       claimReq_o,
  output logic                                       completeReq_o,
  output logic [CtxIdxWidth-1:0]                     ctxSel_o,
  output logic [DataWidth-1:0]                       wdata_o,
  input  logic [SrcIdWidth-1:0]                      claimId_i,
  input  logic [NumContexts-1:0][NumSources-1:0]     enable_i,
  input  logic [NumContexts-1:0][PrioWidth-1:0]      threshold_i
);

  plicOffset_u offset;

  logic inWindow;
  logic isPrio;
  logic isPending;
  logic isCtx;
  logic isThr;
  logic isClaim;
  logic enHit;
  logic [CtxIdxWidth-1:0] enCtx;
  logic wrReq;
  logic [DataWidth-1:0] rdata;

  //////////////////////////////
  // address decode

  assign inWindow = (regAddr_i & ~PlicBaseMask) == PlicBaseAddr;
  assign offset.raw = regAddr_i[OffsetWidth-1:0];

  // priority words sit at the bottom of the window
  assign isPrio = inWindow && offset.src.region == '0 && offset.src.lane == '0;

  assign isPending = inWindow && offset.raw == PendingOffset;

  always_comb begin
    enHit = 1'b0;
    enCtx = '0;
    for (int c = 0; c < NumContexts; c++) begin
      if (offset.raw == OffsetWidth'(EnableOffset + c * EnableStride)) begin
        enHit = inWindow;
        enCtx = CtxIdxWidth'(c);
      end
    end
  end

  assign isCtx = inWindow && offset.ctx.region == CtxRegion && offset.ctx.lane == '0;
  assign isThr = isCtx && offset.ctx.word == CtxWordWidth'(ThresholdReg);
  assign isClaim = isCtx && offset.ctx.word == CtxWordWidth'(ClaimReg);

  //////////////////////////////
  // strobes last the request cycle only

  assign wrReq = regReq_i && regWe_i;

  always_comb begin
    prioWe_o = '0;
    if (wrReq && isPrio) begin
      prioWe_o[offset.src.srcIdx] = 1'b1;
    end
  end

  assign prioWdata_o = regWdata_i[PrioWidth-1:0];

  assign enWe_o = wrReq && enHit;
  assign thrWe_o = wrReq && isThr;
  assign claimReq_o = regReq_i && !regWe_i && isClaim;
  // writing the claim word completes
  assign completeReq_o = wrReq && isClaim;

  assign ctxSel_o = enHit ? enCtx : offset.ctx.ctxIdx;
  assign wdata_o = regWdata_i;

  //////////////////////////////
  // read mux

  always_comb begin
    rdata = '0;
    if (isPrio) begin
      rdata = DataWidth'(prio_i[offset.src.srcIdx]);
    end else if (isPending) begin
      rdata = DataWidth'(pending_i);
    end else if (enHit) begin
      rdata = DataWidth'(enable_i[enCtx]);
    end else if (isThr) begin
      rdata = DataWidth'(threshold_i[offset.ctx.ctxIdx]);
    end else if (isClaim) begin
      rdata = DataWidth'(claimId_i);
    end
  end

  //////////////////////////////
  // response one cycle later

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      regRvalid_o <= 1'b0;
      regErr_o <= 1'b0;
    end else begin
      regRvalid_o <= regReq_i;
      // error sink for anything outside the window
      regErr_o <= regReq_i && !inWindow;
    end
  end

  always_ff @(posedge clk_i) begin
    if (regReq_i) begin
      regRdata_o <= regWe_i ? '0 : rdata;
    end
  end

endmodule

`default_nettype wire

//--- logic/plicGateway.sv
`default_nettype none

module plicGateway import plicPkg::*; (
  input  logic                 clk_i,
  input  logic                 rstN_i,

  // level from the device
  input  logic                 src_i,

  // priority register write
  input  logic                 prioWe_i,
  input  logic [PrioWidth-1:0] prioWdata_i,

  // from the context arbiter
  input  logic                 claim_i,
  input  logic                 complete_i,

  output logic                 pending_o,
  output logic [PrioWidth-1:0] prio_o
);

  logic inService;

  //////////////////////////////
  // pending and in-service

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      pending_o <= 1'b0;
      inService <= 1'b0;
    end else begin
      if (complete_i) begin
        inService <= 1'b0;
      end

      if (claim_i) begin
        // hand the source over to the handler
        pending_o <= 1'b0;
        inService <= 1'b1;
      end else if (src_i && !pending_o && !inService) begin
        pending_o <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // priority

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      prio_o <= '0;
    end else if (prioWe_i) begin
      prio_o <= prioWdata_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/plicPkg.sv
`default_nettype none

package plicPkg;

  //////////////////////////////
  // sizes and counts

  localparam int AddrWidth   = 38;
  localparam int DataWidth   = 32;
  localparam int NumSources  = 8;
  localparam int SrcIdWidth  = 3;
  localparam int NumContexts = 2;
  localparam int PrioWidth   = 3;
  localparam int CtxIdxWidth = $clog2(NumContexts);

  //////////////////////////////
  // PLIC window in the IO map

  localparam logic [AddrWidth-1:0] PlicBaseAddr = 38'h11000000;
  localparam logic [AddrWidth-1:0] PlicBaseMask = 38'h003FFFFF;
  localparam int OffsetWidth = 22;

  //////////////////////////////
  // register map

  localparam logic [OffsetWidth-1:0] PendingOffset = 22'h001000;
  localparam logic [OffsetWidth-1:0] EnableOffset  = 22'h002000;
  localparam logic [OffsetWidth-1:0] EnableStride  = 22'h000080;
  localparam logic [OffsetWidth-1:0] ContextOffset = 22'h200000;
  localparam logic [OffsetWidth-1:0] ContextStride = 22'h001000;

  // word index inside a context block
  localparam int ThresholdReg = 0;
  localparam int ClaimReg     = 1;

  // field widths of the two offset views
  localparam int LaneWidth      = 2;
  localparam int SrcRegionWidth = OffsetWidth - SrcIdWidth - LaneWidth;
  localparam int CtxWordWidth   = $clog2(ContextStride) - LaneWidth;
  localparam int CtxRegionWidth = OffsetWidth - CtxIdxWidth - CtxWordWidth - LaneWidth;

  // region tag of the context blocks
  localparam logic [CtxRegionWidth-1:0] CtxRegion =
    CtxRegionWidth'(ContextOffset >> (OffsetWidth - CtxRegionWidth));

  // one offset read two ways
  typedef union packed {
    logic [OffsetWidth-1:0] raw;
    struct packed {
      logic [SrcRegionWidth-1:0] region;
      logic [SrcIdWidth-1:0]     srcIdx;
      logic [LaneWidth-1:0]      lane;
    } src;
    struct packed {
      logic [CtxRegionWidth-1:0] region;
      logic [CtxIdxWidth-1:0]    ctxIdx;
      logic [CtxWordWidth-1:0]   word;
      logic [LaneWidth-1:0]      lane;
    } ctx;
  } plicOffset_u;

endpackage

`default_nettype wire
